/* sources.f */
+incdir+.
led_panel_pkg.sv
timeout.sv
framebuffer_ram.sv
framebuffer_fetch.sv
scan_sequencer.sv
panel_driver.sv
led_panel_top.sv
tb_led_panel.sv

/* Bender.yml */
package:
  name: led_panel

sources:
  - include_dirs:
      - .
    files:
      - led_panel_pkg.sv
      - timeout.sv
      - framebuffer_ram.sv
      - framebuffer_fetch.sv
      - scan_sequencer.sv
      - panel_driver.sv
      - led_panel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_led_panel.sv

/* tb_led_panel.sv */
// Testbench for the LED matrix controller
// frame buffer model, table of host writes, HUB75 pin monitor

`timescale 1ns/1ps

`include "led_panel_params.svh"

module tb_led_panel;

    import led_panel_pkg::*;

    localparam int reset_writes = 8;
    localparam int table_size = 9;
    localparam int wait_limit = 200;
    localparam int depth = 1 << `LP_ADDR_BITS;

    logic        clk_in = 1'b0;
    logic        reset = 1'b1;
    fb_write_t   fb_wr = '0;
    hub75_pins_t hub75;
    hub75_pins_t prev_pins;

    // host writes, the last one goes in late during frame 0
    fb_write_t   writes [table_size];
    pixel_pair_t model [0:depth-1];
    int unsigned seed_value;

    led_panel_top led_panel_top_i (
        .reset  (reset),
        .clk_in (clk_in),
        .fb_wr  (fb_wr),
        .hub75  (hub75)
    );

    always #50 clk_in = ~clk_in;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    // one clock, sample point 5 ns after the edge
    task automatic next_cycle();
        prev_pins = hub75;
        @(posedge clk_in);
        #5;
        fb_wr.en = 1'b0;
    endtask

    task automatic host_write(input fb_write_t w);
        fb_wr = w;
        model[w.address] = '{bottom: w.bottom, top: w.top};
    endtask

    // red 12+p, green 7+p, blue 1+p
    function automatic logic [2:0] plane_rgb(input logic [15:0] px, input int p);
        return {px[12 + p], px[7 + p], px[1 + p]};
    endfunction

    function automatic logic clk_rose();
        return hub75.panel_clk && !prev_pins.panel_clk;
    endfunction

    // no latch and a dark panel while columns shift
    task automatic wait_clk_rise(input string name);
        int cycles;
        cycles = 0;
        do begin
            next_cycle();
            check({name, " latch"}, 0, hub75.latch);
            check({name, " oe_n"}, 1, hub75.oe_n);
            cycles++;
            if (cycles > wait_limit) give_up({"panel_clk never rose for ", name});
        end while (!clk_rose());
    endtask

    // any extra panel_clk edge here means more than 64 columns
    task automatic wait_latch(input string name);
        int cycles;
        cycles = 0;
        do begin
            next_cycle();
            check({name, " extra panel_clk"}, 0, clk_rose());
            check({name, " oe_n"}, 1, hub75.oe_n);
            cycles++;
            if (cycles > wait_limit) give_up({"latch never came for ", name});
        end while (!hub75.latch);
    endtask

    task automatic measure_oe(input string name, input int expected);
        int cycles;
        int low_cycles;
        cycles = 0;
        while (hub75.oe_n) begin
            next_cycle();
            check({name, " panel_clk"}, 0, clk_rose());
            cycles++;
            if (cycles > wait_limit) give_up({"oe_n never went low for ", name});
        end
        low_cycles = 0;
        while (!hub75.oe_n) begin
            low_cycles++;
            next_cycle();
            check({name, " panel_clk"}, 0, clk_rose());
            if (low_cycles > wait_limit) give_up({"oe_n never went high again for ", name});
        end
        check({name, " oe_n low cycles"}, expected, low_cycles);
    endtask

    initial begin
        string       name;
        pixel_pair_t px;
        logic [9:0]  a;
        logic [5:0]  rgb_expected;
        logic [5:0]  rgb_actual;

        seed_value = $urandom(32'h9e66_f4f7);

        // background pattern, every address bit matters
        for (int i = 0; i < depth; i++) begin
            a = 10'(i);
            px.top = {a, a[9:4]} ^ 16'h3c5a;
            px.bottom = {a[3:0], a, a[9:8]} ^ 16'hc3a5;
            model[i] = px;
            led_panel_top_i.framebuffer_ram_i.mem[i] = px;
        end

        writes[0] = '{en: 1'b1, address: {4'd0, 6'd0}, top: 16'hffff, bottom: 16'h0000};
        writes[1] = '{en: 1'b1, address: {4'd0, 6'd63}, top: 16'h0000, bottom: 16'hffff};
        writes[2] = '{en: 1'b1, address: {4'd1, 6'd5}, top: 16'haaaa, bottom: 16'h5555};
        writes[3] = '{en: 1'b1, address: {4'd7, 6'd32}, top: 16'hf800, bottom: 16'h07e0};
        writes[4] = '{en: 1'b1, address: {4'd15, 6'd37}, top: 16'h001f, bottom: 16'hf81f};
        for (int i = 5; i < reset_writes; i++) begin
            writes[i] = '{en: 1'b1, address: 10'($urandom()),
                          top: 16'($urandom()), bottom: 16'($urandom())};
        end
        // same entry as writes[4], new colours for frame 1
        writes[8] = '{en: 1'b1, address: {4'd15, 6'd37}, top: 16'h7bcf, bottom: 16'h8430};

        // host writes while reset is held, pins must stay idle
        for (int i = 0; i < reset_writes; i++) begin
            host_write(writes[i]);
            next_cycle();
            name = $sformatf("reset cycle %0d", i);
            check({name, " panel_clk"}, 0, hub75.panel_clk);
            check({name, " latch"}, 0, hub75.latch);
            check({name, " oe_n"}, 1, hub75.oe_n);
            check({name, " row_addr"}, 0, hub75.row_addr);
        end
        reset = 1'b0;

        next_cycle();
        check("first cycle panel_clk", 0, hub75.panel_clk);
        check("first cycle latch", 0, hub75.latch);
        check("first cycle oe_n", 1, hub75.oe_n);
        check("first cycle row_addr", 0, hub75.row_addr);

        // two frames, the second one also covers the row wrap
        for (int f = 0; f < 2; f++) begin
            for (int r = 0; r < `LP_HALF_ROWS; r++) begin
                for (int p = 0; p < `LP_PLANES; p++) begin
                    for (int c = 0; c < `LP_COLUMNS; c++) begin
                        name = $sformatf("frame %0d row %0d plane %0d col %0d", f, r, p, c);
                        wait_clk_rise(name);
                        px = model[{4'(r), 6'(c)}];
                        rgb_expected = {plane_rgb(px.top, p), plane_rgb(px.bottom, p)};
                        rgb_actual = {hub75.r0, hub75.g0, hub75.b0,
                                      hub75.r1, hub75.g1, hub75.b1};
                        check(name, rgb_expected, rgb_actual);
                    end
                    // row 15 fully read for this frame
                    if (f == 0 && r == `LP_HALF_ROWS - 1 && p == `LP_PLANES - 1) begin
                        host_write(writes[8]);
                    end
                    name = $sformatf("frame %0d row %0d plane %0d", f, r, p);
                    wait_latch(name);
                    check({name, " row_addr"}, r, hub75.row_addr);
                    measure_oe(name, `LP_DISPLAY_BASE << p);
                end
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* led_panel_top.sv */
// LED matrix controller top level
// frame buffer, fetch, scan sequencer and HUB75 driver

`timescale 1ns/1ps

`include "led_panel_params.svh"

module led_panel_top (
    input  logic                        reset,
    input  logic                        clk_in,
    input  led_panel_pkg::fb_write_t    fb_wr,
    output led_panel_pkg::hub75_pins_t  hub75
);

    import led_panel_pkg::*;

    logic [`LP_COL_BITS-1:0]  column_address;
    logic [`LP_ROW_BITS-1:0]  row_address;
    logic                     pixel_load_start;
    logic [`LP_ADDR_BITS-1:0] ram_address;
    logic                     ram_clk_enable;
    pixel_pair_t              ram_data;
    pixel_pair_t              pixels;
    panel_cmd_t               cmd;

    framebuffer_ram framebuffer_ram_i (
        .reset      (reset),
        .clk_in     (clk_in),
        .wr         (fb_wr),
        .rd_en      (ram_clk_enable),
        .rd_address (ram_address),
        .rd_data    (ram_data)
    );

    framebuffer_fetch framebuffer_fetch_i (
        .reset            (reset),
        .clk_in           (clk_in),
        .column_address   (column_address),
        .row_address      (row_address),
        .pixel_load_start (pixel_load_start),
        .ram_data_in      (ram_data),
        .ram_address      (ram_address),
        .ram_clk_enable   (ram_clk_enable),
        .pixels           (pixels)
    );

    scan_sequencer scan_sequencer_i (
        .reset            (reset),
        .clk_in           (clk_in),
        .column_address   (column_address),
        .row_address      (row_address),
        .pixel_load_start (pixel_load_start),
        .cmd              (cmd)
    );

    panel_driver panel_driver_i (
        .reset  (reset),
        .clk_in (clk_in),
        .cmd    (cmd),
        .pixels (pixels),
        .pins   (hub75)
    );

endmodule

/* panel_driver.sv */
// HUB75 pin driver
// plane bit select, panel clock pulse, latch, output enable and row address

`timescale 1ns/1ps

`include "led_panel_params.svh"

module panel_driver (
    input  logic                        reset,
    input  logic                        clk_in,
    input  led_panel_pkg::panel_cmd_t   cmd,
    input  led_panel_pkg::pixel_pair_t  pixels,
    output led_panel_pkg::hub75_pins_t  pins
);

    localparam int plane_bits = $clog2(`LP_PLANES);

    // lsb of the planes used in each RGB565 field
    localparam int red_lsb = 12;
    localparam int green_lsb = 7;
    localparam int blue_lsb = 1;

    logic                    clk_pending;
    logic                    latch_pending;
    logic                    oe_pending;
    logic [`LP_ROW_BITS-1:0] row_pending;
    logic [2:0]              top_bits;
    logic [2:0]              bottom_bits;

    // {red, green, blue} for one plane
    function automatic logic [2:0] plane_select(
        input logic [`LP_PIXEL_BITS-1:0] pixel,
        input logic [plane_bits-1:0]     plane
    );
        plane_select = {pixel[red_lsb + plane], pixel[green_lsb + plane], pixel[blue_lsb + plane]};
    endfunction

    assign top_bits    = plane_select(pixels.top, cmd.plane);
    assign bottom_bits = plane_select(pixels.bottom, cmd.plane);

    // clock, latch and oe run one stage behind the data
    // so the last rising edge comes before latch
    always_ff @(posedge clk_in) begin
        if (reset) begin
            clk_pending   <= 1'b0;
            latch_pending <= 1'b0;
            oe_pending    <= 1'b0;
            row_pending   <= '0;
        end else begin
            clk_pending   <= cmd.shift;
            latch_pending <= cmd.latch;
            oe_pending    <= cmd.oe;
            row_pending   <= cmd.row;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            {pins.r0, pins.g0, pins.b0} <= 3'b000;
            {pins.r1, pins.g1, pins.b1} <= 3'b000;
            pins.panel_clk <= 1'b0;
            pins.latch     <= 1'b0;
            pins.oe_n      <= 1'b1;
            pins.row_addr  <= '0;
        end else begin
            // data set up with panel_clk low
            if (cmd.shift) begin
                {pins.r0, pins.g0, pins.b0} <= top_bits;
                {pins.r1, pins.g1, pins.b1} <= bottom_bits;
            end
            // rising edge one cycle later
            pins.panel_clk <= clk_pending;
            pins.latch     <= latch_pending;
            pins.oe_n      <= ~oe_pending;
            // row switches with latch, panel is dark then
            if (latch_pending) begin
                pins.row_addr <= row_pending;
            end
        end
    end

endmodule

/* scan_sequencer.sv */
// Scan sequencer for the panel
// walks columns, bit planes and half-rows, issues fetch/shift/latch/display

`timescale 1ns/1ps

`include "led_panel_params.svh"

module scan_sequencer (
    input  logic                       reset,
    input  logic                       clk_in,
    output logic [`LP_COL_BITS-1:0]    column_address,
    output logic [`LP_ROW_BITS-1:0]    row_address,
    output logic                       pixel_load_start,
    output led_panel_pkg::panel_cmd_t  cmd
);

    import led_panel_pkg::*;

    localparam int plane_bits = $clog2(`LP_PLANES);
    localparam int display_bits = $clog2(`LP_DISPLAY_BASE << (`LP_PLANES - 1));

    // pixels show up this many cycles after the start pulse
    localparam logic [1:0] shift_phase = 2'(`LP_FETCH_CYCLES);
    localparam logic [`LP_COL_BITS-1:0] last_column = `LP_COL_BITS'(`LP_COLUMNS - 1);
    localparam logic [plane_bits-1:0] last_plane = plane_bits'(`LP_PLANES - 1);
    localparam logic [`LP_ROW_BITS-1:0] last_row = `LP_ROW_BITS'(`LP_HALF_ROWS - 1);

    scan_state_t             state;
    logic [1:0]              phase;
    logic [`LP_COL_BITS-1:0] column;
    logic [plane_bits-1:0]   plane;
    logic [`LP_ROW_BITS-1:0] half_row;
    logic [display_bits-1:0] display_count;
    logic [display_bits-1:0] display_last;

    // binary-coded on-time for the current plane
    assign display_last = display_bits'((`LP_DISPLAY_BASE << plane) - 1);

    assign column_address   = column;
    assign row_address      = half_row;
    assign pixel_load_start = (state == SCAN_FETCH) && (phase == 2'd0);

    assign cmd.shift = (state == SCAN_FETCH) && (phase == shift_phase);
    assign cmd.latch = (state == SCAN_LATCH);
    assign cmd.oe    = (state == SCAN_DISPLAY);
    assign cmd.plane = plane;
    assign cmd.row   = half_row;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state         <= SCAN_FETCH;
            phase         <= 2'd0;
            column        <= '0;
            plane         <= '0;
            half_row      <= '0;
            display_count <= '0;
        end else begin
            case (state)
                SCAN_FETCH: begin
                    // start, two waits, shift
                    phase <= phase + 2'd1;
                    if (phase == shift_phase) begin
                        phase <= 2'd0;
                        if (column == last_column) begin
                            column <= '0;
                            state  <= SCAN_LATCH;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end
                end
                SCAN_LATCH: begin
                    display_count <= '0;
                    state         <= SCAN_DISPLAY;
                end
                SCAN_DISPLAY: begin
                    display_count <= display_count + 1'b1;
                    if (display_count == display_last) begin
                        state <= SCAN_FETCH;
                        plane <= plane + 1'b1;
                        // all planes shown, next half-row, wraps into a new frame
                        if (plane == last_plane) begin
                            half_row <= (half_row == last_row) ? '0 : half_row + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SCAN_FETCH;
                end
            endcase
        end
    end

endmodule

/* framebuffer_fetch.sv */
// Frame buffer fetch for one column of a half-row
// opens a fixed read window and registers the returned pixel pair

`timescale 1ns/1ps

`include "led_panel_params.svh"

module framebuffer_fetch (
    input  logic                        reset,
    input  logic                        clk_in,
    input  logic [`LP_COL_BITS-1:0]     column_address,
    input  logic [`LP_ROW_BITS-1:0]     row_address,
    input  logic                        pixel_load_start,
    input  led_panel_pkg::pixel_pair_t  ram_data_in,
    output logic [`LP_ADDR_BITS-1:0]    ram_address,
    output logic                        ram_clk_enable,
    output led_panel_pkg::pixel_pair_t  pixels
);

    localparam int counter_width = 2;
    // read data settles one cycle after the first enabled edge
    localparam logic [counter_width-1:0] capture_count = counter_width'(`LP_FETCH_CYCLES - 1);

    logic [counter_width-1:0] load_counter;

    // half-row in the high bits, column in the low bits
    assign ram_address = {row_address, column_address};

    timeout #(
        .counter_width(counter_width)
    ) timeout_pixel_load (
        .reset   (reset),
        .clk_in  (clk_in),
        .start   (pixel_load_start),
        .value   (counter_width'(`LP_FETCH_CYCLES)),
        .counter (load_counter),
        .running (ram_clk_enable)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixels <= '0;
        end else if (load_counter == capture_count) begin
            pixels <= ram_data_in;
        end
    end

endmodule

/* framebuffer_ram.sv */
// Frame buffer memory, 1024 words of top/bottom pixel pairs
// host write port, enabled synchronous read port

`timescale 1ns/1ps

`include "led_panel_params.svh"

module framebuffer_ram (
    input  logic                        reset,
    input  logic                        clk_in,
    input  led_panel_pkg::fb_write_t    wr,
    input  logic                        rd_en,
    input  logic [`LP_ADDR_BITS-1:0]    rd_address,
    output led_panel_pkg::pixel_pair_t  rd_data
);

    import led_panel_pkg::*;

    localparam int depth = 1 << `LP_ADDR_BITS;

    pixel_pair_t mem [0:depth-1];

    // host side, may write at any time
    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            mem[wr.address] <= '{bottom: wr.bottom, top: wr.top};
        end
    end

    // read side
    // old data on a same-address write
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_address];
        end
    end

endmodule

/* timeout.sv */
// Restartable window counter
// running covers the start cycle plus value-1 more, counter counts from 0

`timescale 1ns/1ps

module timeout #(
    parameter int counter_width = 2
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] counter,
    output logic                     running
);

    logic [counter_width-1:0] count_q;
    logic                     busy_q;

    // start clears the count right away, so the start cycle reads as 0
    assign counter = start ? '0 : count_q;
    assign running = start | busy_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count_q <= '0;
            busy_q  <= 1'b0;
        end else if (running) begin
            count_q <= counter + 1'b1;
            // last cycle of the window
            busy_q  <= (counter != value - 1'b1);
        end
    end

endmodule

/* led_panel_pkg.sv */
// LED panel shared types
// host write, RAM word, panel command, scan state and HUB75 pins

`include "led_panel_params.svh"

package led_panel_pkg;

    // one host write into the frame buffer
    // address is {half-row, column}
    typedef struct packed {
        logic                      en;
        logic [`LP_ADDR_BITS-1:0]  address;
        logic [`LP_PIXEL_BITS-1:0] top;
        logic [`LP_PIXEL_BITS-1:0] bottom;
    } fb_write_t;

    // also the RAM word, bottom pixel in the upper half
    typedef struct packed {
        logic [`LP_PIXEL_BITS-1:0] bottom;
        logic [`LP_PIXEL_BITS-1:0] top;
    } pixel_pair_t;

    // sequencer to driver
    typedef struct packed {
        logic                         shift;
        logic                         latch;
        logic                         oe;
        logic [$clog2(`LP_PLANES)-1:0] plane;
        logic [`LP_ROW_BITS-1:0]      row;
    } panel_cmd_t;

    typedef enum logic [1:0] {
        SCAN_FETCH,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_t;

    // r0/g0/b0 drive the top half, r1/g1/b1 the bottom half
    typedef struct packed {
        logic                    r0;
        logic                    g0;
        logic                    b0;
        logic                    r1;
        logic                    g1;
        logic                    b1;
        logic                    panel_clk;
        logic                    latch;
        logic                    oe_n;
        logic [`LP_ROW_BITS-1:0] row_addr;
    } hub75_pins_t;

endpackage

/* led_panel_params.svh */
// LED panel geometry and timing constants
// shared by the package and the RTL blocks

`ifndef LED_PANEL_PARAMS_SVH
`define LED_PANEL_PARAMS_SVH

// panel geometry, scanned as two halves
`define LP_COLUMNS 64
`define LP_HALF_ROWS 16
`define LP_PLANES 4

// frame buffer read window, in clocks
`define LP_FETCH_CYCLES 3

// plane 0 on-time, doubles per plane
`define LP_DISPLAY_BASE 8

// field widths
`define LP_COL_BITS 6
`define LP_ROW_BITS 4
`define LP_ADDR_BITS 10
`define LP_PIXEL_BITS 16

`endif
